/* project.f */
+incdir+verilog
verilog/mshr_pkg.sv
verilog/mshr_alloc.sv
verilog/mshr_entry.sv
verilog/mshr_req_arb.sv
verilog/mshr_top.sv
tests/mshr_tb.sv

/* tests/mshr_tb.sv */
`timescale 1ns/1ps
`include "mshr_settings.svh"

module mshr_tb
    import mshr_pkg::*;
();

    localparam int ENTRY_NUM   = `MSHR_ENTRY_NUM;
    localparam int CLK_PERIOD  = 40;
    localparam int ALLOC_LIMIT = 20;   // cycles to wait for an offer
    localparam int DRAIN_LIMIT = 200;

    typedef enum {OP_ALLOC, OP_FULL, OP_UPDATE, OP_DRAIN, OP_LOOKUP, OP_FILL} op_e;

    typedef struct packed {
        op_e        op;
        int         idx;
        line_addr_t addr;
        int         exp_val;   // offered index, hit flag or request count
    } step_t;

    logic         clk;
    logic         reset;
    logic         alloc_vld;
    mshr_idx_t    alloc_idx;
    logic         alloc_rdy;
    logic         update_en;
    mshr_update_t update_pld;
    logic         downstream_txreq_vld;
    ds_txreq_t    downstream_txreq_pld;
    logic         downstream_txreq_rdy;
    logic         linefill_done;
    mshr_idx_t    linefill_done_idx;
    line_addr_t   lookup_addr;
    logic         lookup_hit;

    step_t       steps[$];
    logic        table_ready;
    int          errors;
    int          checks;
    logic [31:0] lfsr_state;

    // reference model
    mshr_state_t model_state [ENTRY_NUM];
    line_addr_t  model_addr [ENTRY_NUM];
    int          rr_ptr;
    int          held_win;   // winner kept under back-pressure, -1 if none

    mshr_top u_dut (
        .clk                  (clk),
        .reset                (reset),
        .alloc_vld            (alloc_vld),
        .alloc_idx            (alloc_idx),
        .alloc_rdy            (alloc_rdy),
        .update_en            (update_en),
        .update_pld           (update_pld),
        .downstream_txreq_vld (downstream_txreq_vld),
        .downstream_txreq_pld (downstream_txreq_pld),
        .downstream_txreq_rdy (downstream_txreq_rdy),
        .linefill_done        (linefill_done),
        .linefill_done_idx    (linefill_done_idx),
        .lookup_addr          (lookup_addr),
        .lookup_hit           (lookup_hit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        return n;
    endfunction

    function automatic line_addr_t addr_of(input int i);
        return line_addr_t'(32'h10_0000 * (i + 1) + 32'h11 * i);
    endfunction

    // first ST_REQ entry at or after the pointer
    function automatic int next_winner();
        int c;
        for (int k = 0; k < ENTRY_NUM; k++) begin
            c = (rr_ptr + k) % ENTRY_NUM;
            if (model_state[c] == ST_REQ) return c;
        end
        return -1;
    endfunction

    // a stalled winner stays until it is accepted
    function automatic int current_winner();
        if (held_win >= 0) return held_win;
        return next_winner();
    endfunction

    task automatic compare_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic add_step(input op_e op, input int idx, input line_addr_t addr, input int v);
        steps.push_back('{op, idx, addr, v});
    endtask

    task automatic build_table();
        for (int i = 0; i < ENTRY_NUM; i++) add_step(OP_ALLOC, 0, '0, i);
        add_step(OP_FULL, 0, '0, 0);
        add_step(OP_LOOKUP, 0, addr_of(3), 0);   // still in ST_ALLOC
        add_step(OP_UPDATE, 3, addr_of(3), 0);
        add_step(OP_UPDATE, 5, addr_of(5), 0);
        add_step(OP_UPDATE, 1, addr_of(1), 0);
        add_step(OP_LOOKUP, 0, addr_of(3), 1);
        add_step(OP_DRAIN, 0, '0, 3);
        add_step(OP_LOOKUP, 0, addr_of(5), 1);   // waiting for fill
        add_step(OP_UPDATE, 7, addr_of(7), 0);
        add_step(OP_UPDATE, 0, addr_of(0), 0);
        add_step(OP_UPDATE, 2, addr_of(2), 0);
        add_step(OP_UPDATE, 6, addr_of(6), 0);
        add_step(OP_UPDATE, 4, addr_of(4), 0);
        add_step(OP_LOOKUP, 0, addr_of(6), 1);
        add_step(OP_LOOKUP, 0, 26'h3ff_fff0, 0);
        add_step(OP_DRAIN, 0, '0, 5);            // entry 7 held, then 0 after the wrap
        add_step(OP_FILL, 5, '0, 0);
        add_step(OP_LOOKUP, 0, addr_of(5), 0);
        add_step(OP_FILL, 2, '0, 0);
        // entry 5 frees first, so its offer is already registered
        add_step(OP_ALLOC, 0, '0, 5);
        add_step(OP_ALLOC, 0, '0, 2);
        add_step(OP_FULL, 0, '0, 0);
        add_step(OP_LOOKUP, 0, addr_of(2), 0);
    endtask

    // ====================
    // operations, each starts and ends on a falling edge
    // ====================
    task automatic accept_alloc(input int exp_idx);
        int n;
        n = 0;
        while (!alloc_vld && n < ALLOC_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!alloc_vld) begin
            errors++;
            $display("allocator never offered an entry at t=%0t", $time);
        end else begin
            compare_val("alloc_idx", exp_idx, alloc_idx);
            alloc_rdy = 1'b1;
            @(negedge clk);
            alloc_rdy = 1'b0;
            model_state[exp_idx] = ST_ALLOC;
        end
    endtask

    task automatic expect_full();
        repeat (4) begin
            compare_val("alloc_vld", 0, alloc_vld);
            @(negedge clk);
        end
    endtask

    task automatic apply_update(input int idx, input line_addr_t addr);
        update_en            = 1'b1;
        update_pld.alloc_idx = mshr_idx_t'(idx);
        update_pld.line_addr = addr;
        // requests already pending lock their winner at this edge
        if (held_win < 0) held_win = next_winner();
        @(negedge clk);
        update_en = 1'b0;
        model_state[idx] = ST_REQ;
        model_addr[idx]  = addr;
    endtask

    task automatic drain_requests(input int exp_count);
        int   accepted;
        int   cycles;
        int   win;
        logic rdy_bit;
        accepted = 0;
        cycles   = 0;
        win      = current_winner();
        while (win >= 0 && cycles < DRAIN_LIMIT) begin
            compare_val("downstream_txreq_vld", 1, downstream_txreq_vld);
            compare_val("downstream_txreq_pld.idx", win, downstream_txreq_pld.idx);
            compare_val("downstream_txreq_pld.line_addr", model_addr[win],
                        downstream_txreq_pld.line_addr);
            rdy_bit    = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
            downstream_txreq_rdy = rdy_bit;
            if (rdy_bit && downstream_txreq_vld) begin
                accepted++;
            end
            if (rdy_bit) begin
                model_state[win] = ST_WAIT_FILL;
                rr_ptr   = (win + 1) % ENTRY_NUM;
                held_win = -1;
                win      = current_winner();
            end else begin
                held_win = win;
            end
            @(negedge clk);
            cycles++;
        end
        downstream_txreq_rdy = 1'b0;
        if (win >= 0) begin
            errors++;
            $display("drain still had pending requests after %0d cycles", cycles);
        end
        compare_val("downstream_txreq_vld", 0, downstream_txreq_vld);
        compare_val("accepted requests", exp_count, accepted);
    endtask

    task automatic check_lookup(input line_addr_t addr, input int exp_hit);
        lookup_addr = addr;
        #(CLK_PERIOD / 4);
        compare_val("lookup_hit", exp_hit, lookup_hit);
        @(negedge clk);
    endtask

    task automatic release_entry(input int idx);
        linefill_done     = 1'b1;
        linefill_done_idx = mshr_idx_t'(idx);
        @(negedge clk);
        linefill_done = 1'b0;
        model_state[idx] = ST_IDLE;
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int    err_before;
        step_t s;
        reset                = 1'b1;
        alloc_rdy            = 1'b0;
        update_en            = 1'b0;
        update_pld           = '0;
        downstream_txreq_rdy = 1'b0;
        linefill_done        = 1'b0;
        linefill_done_idx    = '0;
        lookup_addr          = '0;
        lfsr_state           = 32'd98707;
        rr_ptr               = 0;
        held_win             = -1;
        errors               = 0;
        checks               = 0;
        table_ready          = 1'b0;
        for (int i = 0; i < ENTRY_NUM; i++) model_state[i] = ST_IDLE;
        build_table();
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_val("alloc_vld", 0, alloc_vld);   // still low from reset
        reset = 1'b0;
        compare_val("downstream_txreq_vld", 0, downstream_txreq_vld);
        @(negedge clk);   // first edge after reset raises the offer
        compare_val("alloc_vld", 1, alloc_vld);
        compare_val("alloc_idx", 0, alloc_idx);
        compare_val("downstream_txreq_vld", 0, downstream_txreq_vld);
        $display("reset check: %s", (errors == 0) ? "ok" : "mismatch");

        foreach (steps[i]) begin
            s = steps[i];
            err_before = errors;
            case (s.op)
                OP_ALLOC:  accept_alloc(s.exp_val);
                OP_FULL:   expect_full();
                OP_UPDATE: apply_update(s.idx, s.addr);
                OP_DRAIN:  drain_requests(s.exp_val);
                OP_LOOKUP: check_lookup(s.addr, s.exp_val);
                OP_FILL:   release_entry(s.idx);
                default: begin
                    errors++;
                    $display("unknown step kind at step %0d", i);
                end
            endcase
            $display("step %0d %s: %s", i, s.op.name(),
                     (errors == err_before) ? "ok" : "mismatch");
        end

        $display("steps %0d, checks %0d, errors %0d", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #(steps.size() * 50 * CLK_PERIOD);
        $display("run timed out before all steps finished");
        $display("test failed");
        $finish;
    end

endmodule

/* verilog/mshr_alloc.sv */
`timescale 1ns/1ps

module mshr_alloc
    import mshr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  mshr_vec_t free,
    input  logic      alloc_rdy,
    output logic      alloc_vld,
    output mshr_idx_t alloc_idx,
    output logic      alloc_fire
);

    localparam int ENTRY_NUM = $bits(mshr_vec_t);

    mshr_idx_t lowest_idx;

    // lowest set bit of free wins
    always_comb begin
        lowest_idx = '0;
        for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
            if (free[i]) begin
                lowest_idx = mshr_idx_t'(i);
            end
        end
    end

    assign alloc_fire = alloc_vld && alloc_rdy;

    // ====================
    // offer register
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            alloc_vld <= 1'b0;
            alloc_idx <= '0;
        end else if (alloc_fire) begin
            alloc_vld <= 1'b0;       // one bubble so free catches up
        end else if (!alloc_vld) begin
            alloc_vld <= |free;
            alloc_idx <= lowest_idx;
        end
    end

    // offered entry must still be idle while it is offered
    a_offer_free: assert property (
        @(posedge clk) disable iff (reset)
        alloc_vld |-> free[alloc_idx]
    );

endmodule

/* verilog/mshr_entry.sv */
`timescale 1ns/1ps

module mshr_entry
    import mshr_pkg::*;
#(
    parameter int ENTRY_ID = 0
)
(
    input  logic         clk,
    input  logic         reset,
    input  logic         alloc_fire,
    input  mshr_idx_t    alloc_idx,
    input  logic         update_en,
    input  mshr_update_t update_pld,
    input  logic         grant,
    input  logic         linefill_done,
    input  mshr_idx_t    linefill_done_idx,
    input  line_addr_t   lookup_addr,
    output logic         free,
    output logic         req,
    output ds_txreq_t    req_pld,
    output logic         match
);

    localparam mshr_idx_t SELF_IDX = mshr_idx_t'(ENTRY_ID);

    mshr_state_t state;
    mshr_state_t state_nxt;
    line_addr_t  line_addr;

    logic alloc_hit;
    logic update_hit;
    logic fill_hit;

    // own index decode
    assign alloc_hit  = alloc_fire && (alloc_idx == SELF_IDX);
    assign update_hit = update_en && (update_pld.alloc_idx == SELF_IDX);
    assign fill_hit   = linefill_done && (linefill_done_idx == SELF_IDX);

    // ====================
    // entry fsm
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (alloc_hit) state_nxt = ST_ALLOC;
            end
            ST_ALLOC: begin
                if (update_hit) state_nxt = ST_REQ;
            end
            ST_REQ: begin
                if (grant) state_nxt = ST_WAIT_FILL; // accepted downstream
            end
            ST_WAIT_FILL: begin
                if (fill_hit) state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (update_hit) begin
            line_addr <= update_pld.line_addr;
        end
    end

    assign free = (state == ST_IDLE);
    assign req  = (state == ST_REQ);

    assign req_pld.line_addr = line_addr;
    assign req_pld.idx       = SELF_IDX;

    // hazard check, only live misses count
    assign match = ((state == ST_REQ) || (state == ST_WAIT_FILL)) && (line_addr == lookup_addr);

    a_update_in_alloc: assert property (
        @(posedge clk) disable iff (reset)
        update_hit |-> state == ST_ALLOC
    );

    a_fill_in_wait: assert property (
        @(posedge clk) disable iff (reset)
        fill_hit |-> state == ST_WAIT_FILL
    );

endmodule

/* verilog/mshr_pkg.sv */
`include "mshr_settings.svh"

package mshr_pkg;

    typedef logic [$clog2(`MSHR_ENTRY_NUM)-1:0] mshr_idx_t;
    typedef logic [`MSHR_ENTRY_NUM-1:0] mshr_vec_t; // one bit per entry
    typedef logic [`MSHR_ADDR_WIDTH-`MSHR_LINE_OFFSET-1:0] line_addr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ALLOC,      // reserved, waiting for the line address
        ST_REQ,        // miss request pending downstream
        ST_WAIT_FILL
    } mshr_state_t;

    // update from the tag pipe
    typedef struct packed {
        mshr_idx_t  alloc_idx;
        line_addr_t line_addr;
    } mshr_update_t;

    // miss request to downstream
    typedef struct packed {
        line_addr_t line_addr;
        mshr_idx_t  idx;
    } ds_txreq_t;

    typedef ds_txreq_t ds_txreq_arr_t [`MSHR_ENTRY_NUM];

endpackage

/* verilog/mshr_req_arb.sv */
`timescale 1ns/1ps

module mshr_req_arb
    import mshr_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  mshr_vec_t     req,
    input  ds_txreq_arr_t req_pld,
    output mshr_vec_t     grant,
    output logic          downstream_txreq_vld,
    output ds_txreq_t     downstream_txreq_pld,
    input  logic          downstream_txreq_rdy
);

    localparam int ENTRY_NUM = $bits(mshr_vec_t);

    mshr_idx_t ptr;
    mshr_idx_t rr_idx;
    logic      rr_found;
    logic      lock;        // stalled last cycle, keep the winner
    mshr_idx_t lock_idx;
    mshr_idx_t sel_idx;
    logic      accept;

    // first requester at or after ptr, wrapping
    always_comb begin
        int cand;
        rr_idx   = ptr;
        rr_found = 1'b0;
        for (int k = 0; k < ENTRY_NUM; k++) begin
            cand = (int'(ptr) + k) % ENTRY_NUM;
            if (!rr_found && req[cand]) begin
                rr_found = 1'b1;
                rr_idx   = mshr_idx_t'(cand);
            end
        end
    end

    assign sel_idx = lock ? lock_idx : rr_idx;

    assign downstream_txreq_vld = |req;
    assign downstream_txreq_pld = req_pld[sel_idx];
    assign accept = downstream_txreq_vld && downstream_txreq_rdy;

    always_comb begin
        grant = '0;
        if (accept) begin
            grant[sel_idx] = 1'b1;
        end
    end

    // ====================
    // pointer and lock
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr  <= '0;
            lock <= 1'b0;
        end else begin
            if (accept) begin
                ptr <= mshr_idx_t'((int'(sel_idx) + 1) % ENTRY_NUM);
            end
            lock <= downstream_txreq_vld && !downstream_txreq_rdy;
        end
    end

    always_ff @(posedge clk) begin
        lock_idx <= sel_idx;
    end

    a_pld_stable: assert property (
        @(posedge clk) disable iff (reset)
        downstream_txreq_vld && !downstream_txreq_rdy
            |=> downstream_txreq_vld && $stable(downstream_txreq_pld)
    );

endmodule

/* verilog/mshr_settings.svh */
`ifndef MSHR_SETTINGS_SVH
`define MSHR_SETTINGS_SVH

// ====================
// mshr sizing
// ====================

// number of miss entries
`define MSHR_ENTRY_NUM 8

// request address width
`define MSHR_ADDR_WIDTH 32

// byte offset bits inside one cache line
`define MSHR_LINE_OFFSET 6

`endif

/* verilog/mshr_top.sv */
`timescale 1ns/1ps
`include "mshr_settings.svh"

module mshr_top
    import mshr_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // allocation to the tag pipe
    output logic         alloc_vld,
    output mshr_idx_t    alloc_idx,
    input  logic         alloc_rdy,

    input  logic         update_en,
    input  mshr_update_t update_pld,

    // miss request downstream
    output logic         downstream_txreq_vld,
    output ds_txreq_t    downstream_txreq_pld,
    input  logic         downstream_txreq_rdy,

    input  logic         linefill_done,
    input  mshr_idx_t    linefill_done_idx,

    // hazard lookup
    input  line_addr_t   lookup_addr,
    output logic         lookup_hit
);

    mshr_vec_t     free_vec;
    mshr_vec_t     req_vec;
    mshr_vec_t     grant_vec;
    mshr_vec_t     match_vec;
    ds_txreq_arr_t req_pld_arr;
    logic          alloc_fire;

    // ====================
    // allocator
    // ====================
    mshr_alloc u_alloc (
        .clk        (clk),
        .reset      (reset),
        .free       (free_vec),
        .alloc_rdy  (alloc_rdy),
        .alloc_vld  (alloc_vld),
        .alloc_idx  (alloc_idx),
        .alloc_fire (alloc_fire)
    );

    // ====================
    // entries
    // ====================
    generate
        for (genvar i = 0; i < `MSHR_ENTRY_NUM; i++) begin : g_entry
            mshr_entry #(
                .ENTRY_ID (i)
            ) u_entry (
                .clk               (clk),
                .reset             (reset),
                .alloc_fire        (alloc_fire),
                .alloc_idx         (alloc_idx),
                .update_en         (update_en),
                .update_pld        (update_pld),
                .grant             (grant_vec[i]),
                .linefill_done     (linefill_done),
                .linefill_done_idx (linefill_done_idx),
                .lookup_addr       (lookup_addr),
                .free              (free_vec[i]),
                .req               (req_vec[i]),
                .req_pld           (req_pld_arr[i]),
                .match             (match_vec[i])
            );
        end
    endgenerate

    // miss requests to downstream
    mshr_req_arb u_req_arb (
        .clk                  (clk),
        .reset                (reset),
        .req                  (req_vec),
        .req_pld              (req_pld_arr),
        .grant                (grant_vec),
        .downstream_txreq_vld (downstream_txreq_vld),
        .downstream_txreq_pld (downstream_txreq_pld),
        .downstream_txreq_rdy (downstream_txreq_rdy)
    );

    assign lookup_hit = |match_vec;

endmodule
